// File: include/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// one output port sees five input ports, index 0..4 is L, N, E, W, S.
`define NOC_PORTS 5
// entries per flit queue, must be a power of two.
`define NOC_QUEUE_DEPTH 4
`define NOC_DATA_W 16
`define NOC_LEN_W 12
`define NOC_KIND_W 3
`define NOC_PORT_W 3

`endif

// File: hw/nocPkg.sv
`include "noc_macros.svh"

package nocPkg;

  typedef logic [`NOC_KIND_W-1:0] flitKindT;
  typedef logic [`NOC_DATA_W-1:0] flitDataT;
  typedef logic [`NOC_LEN_W-1:0] holdLenT;
  typedef logic [`NOC_PORT_W-1:0] portIdT;

  // a head flit carries the hold length in the low bits of its payload.
  localparam flitKindT FLIT_HEAD = 3'd1;
  localparam flitKindT FLIT_BODY = 3'd2;
  localparam flitKindT FLIT_TAIL = 3'd3;

  // grant states follow the port index, ARB_L is port 0.
  typedef enum logic [2:0] {
    ARB_IDLE = 3'd0,
    ARB_L    = 3'd1,
    ARB_N    = 3'd2,
    ARB_E    = 3'd3,
    ARB_W    = 3'd4,
    ARB_S    = 3'd5
  } arbStateT;

endpackage

// File: hw/flitQueue.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module flitQueue
  import nocPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     inValid,
  input  flitKindT inKind,
  input  flitDataT inData,
  input  logic     pop,
  output logic     inReady,
  output logic     headValid,
  output flitKindT headKind,
  output flitDataT headData
);

  localparam int Depth = `NOC_QUEUE_DEPTH;
  localparam int PtrW = $clog2(Depth);

  flitKindT kindMem [Depth];
  flitDataT dataMem [Depth];

  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [PtrW:0]   count;
  logic            accept;

  assign inReady   = (count != (PtrW + 1)'(Depth));
  assign headValid = (count != '0);
  assign accept    = inValid && inReady;
  assign headKind  = kindMem[rdPtr];
  assign headData  = dataMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      kindMem[wrPtr] <= inKind;
      dataMem[wrPtr] <= inData;
    end
  end

  // pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (accept)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      case ({accept, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the link stage may only pop a queue that has a flit at its head.
  popNeedsHead: assert property (@(posedge clk) disable iff (rst) pop |-> headValid);

endmodule

// File: hw/holdTimer.sv
`timescale 1ns/1ps

module holdTimer
  import nocPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     headValid,
  input  flitKindT headKind,
  input  holdLenT  headLen,
  input  logic     holding,
  output logic     expired
);

  holdLenT holdLen;
  holdLenT count;

  // the length is refreshed each cycle a head flit waits at the queue head.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLen <= '0;
      count   <= '0;
    end
    else
    begin
      if (headValid && headKind == FLIT_HEAD)
        holdLen <= headLen;
      if (holding)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign expired = (count == holdLen);

endmodule

// File: hw/outputArbiter.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module outputArbiter
  import nocPkg::*;
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic     [`NOC_PORTS-1:0]           headValid,
  input  flitKindT [`NOC_PORTS-1:0]           headKind,
  input  flitDataT [`NOC_PORTS-1:0]           headData,
  output logic     [`NOC_PORTS-1:0]           grant
);

  arbStateT state;
  arbStateT nextState;
  portIdT   curIdx;

  logic [`NOC_PORTS-1:0] expired;
  logic [`NOC_PORTS-1:0] holding;

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : genPort
    // a port's window runs only while it keeps the grant, so a re-won grant starts fresh.
    assign holding[p] = grant[p];
    assign grant[p]   = (state == arbStateT'(3'(p + 1)));

    holdTimer timer (
      .clk       (clk),
      .rst       (rst),
      .headValid (headValid[p]),
      .headKind  (headKind[p]),
      .headLen   (holdLenT'(headData[p][`NOC_LEN_W-1:0])),
      .holding   (holding[p]),
      .expired   (expired[p])
    );
  end

  // idle searches as if S held the grant, which gives the order L, N, E, W, S.
  assign curIdx = (state == ARB_IDLE) ? portIdT'(`NOC_PORTS - 1) : portIdT'(state) - 3'd1;

  always_comb
  begin
    int unsigned cand;
    nextState = ARB_IDLE;
    // walk the rotation backwards so the nearest requester after curIdx wins.
    for (int k = `NOC_PORTS; k >= 1; k--)
    begin
      cand = (int'(curIdx) + k) % `NOC_PORTS;
      if (headValid[cand])
        nextState = arbStateT'(3'(cand + 1));
    end
    if (state != ARB_IDLE && headValid[curIdx] && !expired[curIdx])
      nextState = state;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ARB_IDLE;
    else
      state <= nextState;
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

endmodule

// File: hw/linkStage.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module linkStage
  import nocPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic     [`NOC_PORTS-1:0] grant,
  input  logic     [`NOC_PORTS-1:0] headValid,
  input  flitKindT [`NOC_PORTS-1:0] headKind,
  input  flitDataT [`NOC_PORTS-1:0] headData,
  input  logic                      outReady,
  output logic     [`NOC_PORTS-1:0] pop,
  output logic                      outValid,
  output flitKindT                  outKind,
  output flitDataT                  outData,
  output portIdT                    outPort
);

  flitKindT selKind;
  flitDataT selData;
  portIdT   selPort;
  logic     canTake;

  // grant is one-hot, so at most one head is selected.
  always_comb
  begin
    selKind = '0;
    selData = '0;
    selPort = '0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      if (grant[p])
      begin
        selKind = headKind[p];
        selData = headData[p];
        selPort = portIdT'(p);
      end
    end
  end

  assign canTake = !outValid || outReady;
  assign pop     = grant & headValid & {`NOC_PORTS{canTake}};

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (|pop)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outKind <= selKind;
      outData <= selData;
      outPort <= selPort;
    end
  end

  outputStable: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outKind) && $stable(outData)
      && $stable(outPort)));

endmodule

// File: hw/routerOutput.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module routerOutput
  import nocPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic     [`NOC_PORTS-1:0] inValid,
  input  flitKindT [`NOC_PORTS-1:0] inKind,
  input  flitDataT [`NOC_PORTS-1:0] inData,
  output logic     [`NOC_PORTS-1:0] inReady,
  output logic                      outValid,
  output flitKindT                  outKind,
  output flitDataT                  outData,
  output portIdT                    outPort,
  input  logic                      outReady
);

  logic     [`NOC_PORTS-1:0] headValid;
  flitKindT [`NOC_PORTS-1:0] headKind;
  flitDataT [`NOC_PORTS-1:0] headData;
  logic     [`NOC_PORTS-1:0] grant;
  logic     [`NOC_PORTS-1:0] pop;

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : genQueue
    flitQueue queue (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[p]),
      .inKind    (inKind[p]),
      .inData    (inData[p]),
      .pop       (pop[p]),
      .inReady   (inReady[p]),
      .headValid (headValid[p]),
      .headKind  (headKind[p]),
      .headData  (headData[p])
    );
  end

  outputArbiter arbiter (
    .clk       (clk),
    .rst       (rst),
    .headValid (headValid),
    .headKind  (headKind),
    .headData  (headData),
    .grant     (grant)
  );

  linkStage link (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .headValid (headValid),
    .headKind  (headKind),
    .headData  (headData),
    .outReady  (outReady),
    .pop       (pop),
    .outValid  (outValid),
    .outKind   (outKind),
    .outData   (outData),
    .outPort   (outPort)
  );

endmodule

// File: sim/routerOutputTb.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module routerOutputTb
  import nocPkg::*;
;

  localparam int EntryW = $bits(flitKindT) + $bits(flitDataT);
  typedef logic [EntryW-1:0] entryT;

  logic                      clk;
  logic                      rst;
  logic     [`NOC_PORTS-1:0] inValid;
  flitKindT [`NOC_PORTS-1:0] inKind;
  flitDataT [`NOC_PORTS-1:0] inData;
  logic     [`NOC_PORTS-1:0] inReady;
  logic                      outValid;
  flitKindT                  outKind;
  flitDataT                  outData;
  portIdT                    outPort;
  logic                      outReady;

  // stimulus is kept per phase and port, index is phase * ports + port.
  entryT stimQ [2*`NOC_PORTS][$];
  entryT expQ [`NOC_PORTS][$];
  int    acceptCnt [`NOC_PORTS];
  int    offerCnt [`NOC_PORTS];
  int    phaseCount [2];
  int    inCount;
  int    outCount;
  int    totalFlits;
  int    cycles;
  int    limit;
  int    phaseNum;
  logic [15:0] lfsr;
  logic     stallSeen;
  flitKindT heldKind;
  flitDataT heldData;
  portIdT   heldPort;

  routerOutput uut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inKind   (inKind),
    .inData   (inData),
    .inReady  (inReady),
    .outValid (outValid),
    .outKind  (outKind),
    .outData  (outData),
    .outPort  (outPort),
    .outReady (outReady)
  );

  always #4 clk = ~clk;

  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb)
      s = s ^ 16'hB400;
    return s;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      failRun($sformatf("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic readStimulus();
    int    fd;
    int    n;
    int    port;
    int    kind;
    int    curPhase;
    logic [15:0] data;
    string line;
    curPhase = 0;
    fd = $fopen("sim/flitInput.txt", "r");
    if (fd == 0)
      failRun("could not open sim/flitInput.txt");
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line[0] == "#")
        continue;
      if (line[0] == "p")
      begin
        curPhase++;
        continue;
      end
      n = $sscanf(line, "%d %d %h", port, kind, data);
      if (n != 3 || curPhase < 1 || curPhase > 2 || port < 0 || port >= `NOC_PORTS)
        failRun($sformatf("bad stimulus record: %s", line));
      stimQ[(curPhase - 1) * `NOC_PORTS + port].push_back({flitKindT'(kind), data});
      phaseCount[curPhase - 1]++;
    end
    $fclose(fd);
    totalFlits = phaseCount[0] + phaseCount[1];
    limit = 20 * totalFlits + 100;
  endtask

  task automatic checkResetState();
    checkVal(32'(outValid), 32'd0, "outValid during reset");
    checkVal(32'(inReady), 32'h1f, "inReady during reset");
  endtask

  // phase 1 holds outReady low until every offered flit is in a queue.
  task automatic runPhase(input int ph, input bit randomStim, input int target);
    int    base;
    bit    go;
    entryT e;
    base = ph * `NOC_PORTS;
    while (outCount < target)
    begin
      @(negedge clk);
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        if (inValid[p] && acceptCnt[p] == offerCnt[p])
          inValid[p] = 1'b0;
        if (!inValid[p] && stimQ[base + p].size() > 0)
        begin
          go = 1'b1;
          if (randomStim)
          begin
            lfsr = lfsrStep(lfsr);
            go = lfsr[0];
          end
          if (go)
          begin
            e = stimQ[base + p].pop_front();
            {inKind[p], inData[p]} = e;
            inValid[p] = 1'b1;
            offerCnt[p]++;
          end
        end
      end
      if (randomStim)
      begin
        lfsr = lfsrStep(lfsr);
        outReady = lfsr[0];
      end
      else if (inValid == '0)
        outReady = 1'b1;
    end
    @(negedge clk);
    inValid = '0;
    outReady = 1'b1;
  endtask

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > limit)
      failRun($sformatf("timeout after %0d cycles with %0d of %0d flits out",
        cycles, outCount, totalFlits));
  end

  always @(posedge clk)
  begin
    entryT front;
    int    port;
    if (!rst)
    begin
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        if (inValid[p] && inReady[p])
        begin
          expQ[p].push_back({inKind[p], inData[p]});
          acceptCnt[p]++;
          inCount++;
        end
      end
      if (stallSeen)
      begin
        checkVal(32'(outKind), 32'(heldKind), "outKind held under back-pressure");
        checkVal(32'(outData), 32'(heldData), "outData held under back-pressure");
        checkVal(32'(outPort), 32'(heldPort), "outPort held under back-pressure");
      end
      stallSeen = outValid && !outReady;
      heldKind = outKind;
      heldData = outData;
      heldPort = outPort;
      if (outValid && outReady)
      begin
        port = int'(outPort);
        if (port >= `NOC_PORTS)
          failRun($sformatf("output flit carries invalid source port %0d", port));
        if (expQ[port].size() == 0)
          failRun($sformatf("output flit from port %0d was never sent in", port));
        // with one flit per port the rotation from idle gives L, N, E, W, S.
        if (phaseNum == 1)
          checkVal(32'(outPort), 32'(outCount % `NOC_PORTS), "phase 1 rotation order");
        front = expQ[port].pop_front();
        checkVal(32'(outKind), 32'(front[EntryW-1 -: $bits(flitKindT)]), "output kind");
        checkVal(32'(outData), 32'(front[$bits(flitDataT)-1:0]), "output data");
        outCount++;
      end
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = '0;
    inKind = '0;
    inData = '0;
    outReady = 1'b0;
    stallSeen = 1'b0;
    lfsr = 16'd28;
    cycles = 0;
    limit = 100;
    phaseNum = 0;
    readStimulus();
    repeat (4)
    begin
      @(negedge clk);
      checkResetState();
    end
    rst = 1'b0;
    @(negedge clk);
    checkResetState();
    phaseNum = 1;
    runPhase(0, 1'b0, phaseCount[0]);
    phaseNum = 2;
    runPhase(1, 1'b1, totalFlits);
    for (int p = 0; p < `NOC_PORTS; p++)
      checkVal(32'(expQ[p].size()), 32'd0, $sformatf("expected FIFO of port %0d empty", p));
    checkVal(32'(outCount), 32'(inCount), "output count equals input count");
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: all.f
+incdir+include
hw/nocPkg.sv
hw/flitQueue.sv
hw/holdTimer.sv
hw/outputArbiter.sv
hw/linkStage.sv
hw/routerOutput.sv
sim/routerOutputTb.sv

// File: Makefile
TOOL       := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
TOP        := routerOutputTb
FLIST      := all.f
BUILD      := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/flitInput.txt
# columns: port (0..4 is L N E W S), kind (1 head, 2 body, 3 tail), data in hex
# a head flit carries its hold length in data[11:0]; a line "phase N" starts a phase
phase 1
0 1 a000
1 1 b000
2 1 c000
3 1 d000
4 1 e000
phase 2
0 1 1003
0 2 1111
0 3 1222
1 1 2002
1 3 2333
2 1 3004
2 2 3444
2 2 3555
2 3 3666
3 1 4001
3 3 4777
4 1 5005
4 2 5888
4 3 5999
0 1 6002
0 3 6aaa
